/* vshift_config.svh */
`ifndef VSHIFT_CONFIG_SVH
`define VSHIFT_CONFIG_SVH

// vector register width in bits
`define VSHIFT_VLEN     128

// element widths
`define VSHIFT_BYTE_W   8
`define VSHIFT_HWORD_W  16
`define VSHIFT_WORD_W   32

// scalar operand width
`define VSHIFT_XLEN     32

// cycles from accepted uop to result
`define VSHIFT_LATENCY  2

`endif

/* vshift_pkg.sv */
`include "vshift_config.svh"

package vshift_pkg;

  typedef logic [`VSHIFT_VLEN-1:0]    vlen_t;
  typedef logic [`VSHIFT_XLEN-1:0]    xlen_t;

  // lane element types
  typedef logic [`VSHIFT_BYTE_W-1:0]  byte_t;
  typedef logic [`VSHIFT_HWORD_W-1:0] hword_t;
  typedef logic [`VSHIFT_WORD_W-1:0]  word_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  // narrowing codes only kept so they can be rejected
  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNSRL   = 6'b101100,
    VNSRA   = 6'b101101,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } funct6_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  typedef enum logic [1:0] {
    RNU = 2'b00,
    RNE = 2'b01,
    RDN = 2'b10,
    ROD = 2'b11
  } vxrm_e;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'b00,
    SHIFT_SRL = 2'b01,
    SHIFT_SRA = 2'b10
  } shift_op_e;

endpackage

/* vshift_ctrl.sv */
`timescale 1ns/1ps
`include "vshift_config.svh"

module vshift_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  input  vshift_pkg::funct3_e   funct3,
  input  vshift_pkg::funct6_e   funct6,
  input  vshift_pkg::vxrm_e     vxrm,
  input  vshift_pkg::eew_e      vs2_eew,
  input  vshift_pkg::vlen_t     vs1_data,
  input  logic                  vs1_data_valid,
  input  vshift_pkg::vlen_t     vs2_data,
  input  logic                  vs2_data_valid,
  input  vshift_pkg::xlen_t     rs1_data,
  input  logic                  rs1_data_valid,
  output logic                  issue_valid,
  output logic                  scale,
  output logic                  use_scalar,
  output vshift_pkg::shift_op_e shift_op,
  output vshift_pkg::vxrm_e     vxrm_q,
  output vshift_pkg::eew_e      eew_q,
  output vshift_pkg::vlen_t     src_data,
  output vshift_pkg::vlen_t     amt_vec,
  output logic [4:0]            amt_scalar
);

  import vshift_pkg::*;

  localparam int AMT_W = $clog2(`VSHIFT_WORD_W);

  logic      cat_ok;
  logic      func_ok;
  logic      amt_ok;
  logic      scalar_src;
  logic      accept;
  logic      scale_d;
  shift_op_e op_d;

  // operand category and amount source
  always_comb begin
    cat_ok     = 1'b1;
    scalar_src = 1'b0;
    amt_ok     = 1'b0;
    case (funct3)
      OPIVV: begin
        amt_ok = vs1_data_valid;
      end
      OPIVX, OPIVI: begin
        scalar_src = 1'b1;
        amt_ok     = rs1_data_valid;
      end
      default: begin
        cat_ok = 1'b0;
      end
    endcase
  end

  // shift kind, narrowing codes fall to default
  always_comb begin
    func_ok = 1'b1;
    scale_d = 1'b0;
    op_d    = SHIFT_SLL;
    case (funct6)
      VSLL:  op_d = SHIFT_SLL;
      VSRL:  op_d = SHIFT_SRL;
      VSRA:  op_d = SHIFT_SRA;
      VSSRL: begin
        op_d    = SHIFT_SRL;
        scale_d = 1'b1;
      end
      VSSRA: begin
        op_d    = SHIFT_SRA;
        scale_d = 1'b1;
      end
      default: func_ok = 1'b0;
    endcase
  end

  assign accept = uop_valid & cat_ok & func_ok & vs2_data_valid & amt_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= accept;
    end
  end

  // issue payload, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_op   <= op_d;
      scale      <= scale_d;
      vxrm_q     <= vxrm;
      eew_q      <= vs2_eew;
      src_data   <= vs2_data;
      amt_vec    <= vs1_data;
      amt_scalar <= rs1_data[AMT_W-1:0];
      use_scalar <= scalar_src;
    end
  end

endmodule

/* vshift_amount_gen.sv */
`timescale 1ns/1ps
`include "vshift_config.svh"

module vshift_amount_gen (
  input  vshift_pkg::eew_e  eew,
  input  logic              use_scalar,
  input  vshift_pkg::vlen_t amt_vec,
  input  logic [4:0]        amt_scalar,
  output vshift_pkg::vlen_t amounts
);

  import vshift_pkg::*;

  localparam int VLEN    = `VSHIFT_VLEN;
  localparam int BYTE_W  = `VSHIFT_BYTE_W;
  localparam int HWORD_W = `VSHIFT_HWORD_W;
  localparam int WORD_W  = `VSHIFT_WORD_W;

  // broadcast scalar into the low bits of each slot
  always_comb begin
    amounts = amt_vec;
    if (use_scalar) begin
      amounts = '0;
      case (eew)
        EEW8: begin
          for (int i = 0; i < VLEN / BYTE_W; i++) begin
            amounts[i*BYTE_W +: 5] = amt_scalar;
          end
        end
        EEW16: begin
          for (int i = 0; i < VLEN / HWORD_W; i++) begin
            amounts[i*HWORD_W +: 5] = amt_scalar;
          end
        end
        EEW32: begin
          for (int i = 0; i < VLEN / WORD_W; i++) begin
            amounts[i*WORD_W +: 5] = amt_scalar;
          end
        end
        default: begin
          amounts = '0;
        end
      endcase
    end
  end

endmodule

/* vshift_lane_array.sv */
`timescale 1ns/1ps
`include "vshift_config.svh"

module vshift_lane_array #(
  parameter type elem_t = vshift_pkg::byte_t
) (
  input  vshift_pkg::shift_op_e shift_op,
  input  vshift_pkg::vxrm_e     vxrm,
  input  vshift_pkg::vlen_t     src,
  input  vshift_pkg::vlen_t     amounts,
  output vshift_pkg::vlen_t     shifted,
  output vshift_pkg::vlen_t     rounded
);

  import vshift_pkg::*;

  localparam int W     = $bits(elem_t);
  localparam int LANES = `VSHIFT_VLEN / W;
  localparam int AMT_W = $clog2(W);

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    elem_t            elem;
    logic [AMT_W-1:0] amt;
    logic [2*W-1:0]   wide;
    elem_t            sh_val;
    elem_t            rnd_bits;
    logic             r_bit;
    logic             s_bit;
    logic             l_bit;
    logic             inc;

    assign elem = src[i*W +: W];
    assign amt  = amounts[i*W +: AMT_W];

    // element sits in the upper half, shifted-out bits land below it
    always_comb begin
      case (shift_op)
        SHIFT_SLL: wide = {elem, {W{1'b0}}} << amt;
        SHIFT_SRL: wide = {elem, {W{1'b0}}} >> amt;
        SHIFT_SRA: wide = $signed({elem, {W{1'b0}}}) >>> amt;
        default:   wide = '0;
      endcase
    end

    assign sh_val   = wide[2*W-1:W];
    assign rnd_bits = wide[W-1:0];

    assign r_bit = rnd_bits[W-1];
    assign s_bit = |rnd_bits[W-2:0];
    // tie-break uses the shifted value's lsb
    assign l_bit = sh_val[0];

    always_comb begin
      case (vxrm)
        RNU:     inc = r_bit;
        RNE:     inc = r_bit & (s_bit | l_bit);
        RDN:     inc = 1'b0;
        ROD:     inc = ~l_bit & (r_bit | s_bit);
        default: inc = 1'b0;
      endcase
    end

    assign shifted[i*W +: W] = sh_val;
    // wraps within the element
    assign rounded[i*W +: W] = sh_val + elem_t'(inc);
  end

endmodule

/* vshift_result_mux.sv */
`timescale 1ns/1ps

module vshift_result_mux (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              issue_valid,
  input  logic              scale,
  input  vshift_pkg::eew_e  eew,
  input  vshift_pkg::vlen_t shifted8,
  input  vshift_pkg::vlen_t shifted16,
  input  vshift_pkg::vlen_t shifted32,
  input  vshift_pkg::vlen_t rounded8,
  input  vshift_pkg::vlen_t rounded16,
  input  vshift_pkg::vlen_t rounded32,
  output logic              result_valid,
  output vshift_pkg::vlen_t result_data
);

  import vshift_pkg::*;

  vlen_t sel_data;

  // width first, then rounded or plain
  always_comb begin
    case (eew)
      EEW8:    sel_data = scale ? rounded8  : shifted8;
      EEW16:   sel_data = scale ? rounded16 : shifted16;
      EEW32:   sel_data = scale ? rounded32 : shifted32;
      default: sel_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      result_data <= sel_data;
    end
  end

endmodule

/* vshift_unit.sv */
`timescale 1ns/1ps

module vshift_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                uop_valid,
  input  vshift_pkg::funct3_e funct3,
  input  vshift_pkg::funct6_e funct6,
  input  vshift_pkg::vxrm_e   vxrm,
  input  vshift_pkg::eew_e    vs2_eew,
  input  vshift_pkg::vlen_t   vs1_data,
  input  logic                vs1_data_valid,
  input  vshift_pkg::vlen_t   vs2_data,
  input  logic                vs2_data_valid,
  input  vshift_pkg::xlen_t   rs1_data,
  input  logic                rs1_data_valid,
  output logic                result_valid,
  output vshift_pkg::vlen_t   result_data
);

  import vshift_pkg::*;

  // issue stage
  logic       issue_valid;
  logic       scale;
  logic       use_scalar;
  shift_op_e  shift_op;
  vxrm_e      vxrm_q;
  eew_e       eew_q;
  vlen_t      src_data;
  vlen_t      amt_vec;
  logic [4:0] amt_scalar;

  vlen_t      amounts;
  vlen_t      shifted8;
  vlen_t      shifted16;
  vlen_t      shifted32;
  vlen_t      rounded8;
  vlen_t      rounded16;
  vlen_t      rounded32;

  vshift_ctrl u_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (uop_valid),
    .funct3         (funct3),
    .funct6         (funct6),
    .vxrm           (vxrm),
    .vs2_eew        (vs2_eew),
    .vs1_data       (vs1_data),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data       (vs2_data),
    .vs2_data_valid (vs2_data_valid),
    .rs1_data       (rs1_data),
    .rs1_data_valid (rs1_data_valid),
    .issue_valid    (issue_valid),
    .scale          (scale),
    .use_scalar     (use_scalar),
    .shift_op       (shift_op),
    .vxrm_q         (vxrm_q),
    .eew_q          (eew_q),
    .src_data       (src_data),
    .amt_vec        (amt_vec),
    .amt_scalar     (amt_scalar)
  );

  vshift_amount_gen u_amount_gen (
    .eew        (eew_q),
    .use_scalar (use_scalar),
    .amt_vec    (amt_vec),
    .amt_scalar (amt_scalar),
    .amounts    (amounts)
  );

  // one lane array per element width
  vshift_lane_array #(.elem_t(byte_t)) u_lanes8 (
    .shift_op (shift_op),
    .vxrm     (vxrm_q),
    .src      (src_data),
    .amounts  (amounts),
    .shifted  (shifted8),
    .rounded  (rounded8)
  );

  vshift_lane_array #(.elem_t(hword_t)) u_lanes16 (
    .shift_op (shift_op),
    .vxrm     (vxrm_q),
    .src      (src_data),
    .amounts  (amounts),
    .shifted  (shifted16),
    .rounded  (rounded16)
  );

  vshift_lane_array #(.elem_t(word_t)) u_lanes32 (
    .shift_op (shift_op),
    .vxrm     (vxrm_q),
    .src      (src_data),
    .amounts  (amounts),
    .shifted  (shifted32),
    .rounded  (rounded32)
  );

  vshift_result_mux u_result_mux (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_valid  (issue_valid),
    .scale        (scale),
    .eew          (eew_q),
    .shifted8     (shifted8),
    .shifted16    (shifted16),
    .shifted32    (shifted32),
    .rounded8     (rounded8),
    .rounded16    (rounded16),
    .rounded32    (rounded32),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

endmodule

/* vshift_properties.sv */
`timescale 1ns/1ps
`include "vshift_config.svh"

module vshift_properties (
  input logic                clk,
  input logic                arst_n,
  input logic                uop_valid,
  input vshift_pkg::funct3_e funct3,
  input vshift_pkg::funct6_e funct6,
  input logic                vs1_data_valid,
  input logic                vs2_data_valid,
  input logic                rs1_data_valid,
  input logic                result_valid
);

  import vshift_pkg::*;

  logic accepted;

  assign accepted = uop_valid && (funct3 inside {OPIVV, OPIVX, OPIVI}) &&
                    (funct6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA}) && vs2_data_valid &&
                    ((funct3 == OPIVV) ? vs1_data_valid : rs1_data_valid);

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(result_valid))
    else $error("result_valid is unknown");

  a_result_follows: assert property (@(posedge clk) disable iff (!arst_n)
    accepted |-> ##(`VSHIFT_LATENCY) result_valid)
    else $error("accepted uop gave no result after the pipeline latency");

  // no result without an accepted uop two edges back
  a_no_stray_result: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid |-> $past(accepted, `VSHIFT_LATENCY))
    else $error("result_valid without an accepted uop");

endmodule

bind vshift_unit vshift_properties u_props (
  .clk            (clk),
  .arst_n         (arst_n),
  .uop_valid      (uop_valid),
  .funct3         (funct3),
  .funct6         (funct6),
  .vs1_data_valid (vs1_data_valid),
  .vs2_data_valid (vs2_data_valid),
  .rs1_data_valid (rs1_data_valid),
  .result_valid   (result_valid)
);

/* tb_vshift_unit.sv */
`timescale 1ns/1ps
`include "vshift_config.svh"

module tb_vshift_unit;

  import vshift_pkg::*;

  localparam int VLEN     = `VSHIFT_VLEN;
  localparam int LAT      = `VSHIFT_LATENCY;
  localparam int N_RANDOM = 200;
  // reset, uops of all tests, and a drain allowance per test
  localparam int STIM_CYCLES    = 2 + 18 + 18 + 72 + 10 + N_RANDOM + 6 * 8;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 50;

  logic    clk = 1'b0;
  logic    arst_n;
  logic    uop_valid;
  funct3_e funct3;
  funct6_e funct6;
  vxrm_e   vxrm;
  eew_e    vs2_eew;
  vlen_t   vs1_data;
  logic    vs1_data_valid;
  vlen_t   vs2_data;
  logic    vs2_data_valid;
  xlen_t   rs1_data;
  logic    rs1_data_valid;
  logic    result_valid;
  vlen_t   result_data;

  int      cycle_cnt = 0;
  int      err_count = 0;
  int      test_err_base = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  vlen_t   exp_q[$];
  int      issue_q[$];

  funct6_e plain_ops[3] = '{VSLL, VSRL, VSRA};
  funct6_e scale_ops[2] = '{VSSRL, VSSRA};
  funct6_e kept_ops[5]  = '{VSLL, VSRL, VSRA, VSSRL, VSSRA};
  funct3_e cats[3]      = '{OPIVV, OPIVX, OPIVI};
  eew_e    widths[3]    = '{EEW8, EEW16, EEW32};
  vxrm_e   modes[4]     = '{RNU, RNE, RDN, ROD};

  vshift_unit uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (uop_valid),
    .funct3         (funct3),
    .funct6         (funct6),
    .vxrm           (vxrm),
    .vs2_eew        (vs2_eew),
    .vs1_data       (vs1_data),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data       (vs2_data),
    .vs2_data_valid (vs2_data_valid),
    .rs1_data       (rs1_data),
    .rs1_data_valid (rs1_data_valid),
    .result_valid   (result_valid),
    .result_data    (result_data)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic int elem_width(eew_e ew);
    case (ew)
      EEW8:    return `VSHIFT_BYTE_W;
      EEW16:   return `VSHIFT_HWORD_W;
      default: return `VSHIFT_WORD_W;
    endcase
  endfunction

  function automatic bit is_accepted(logic uv, funct3_e f3, funct6_e f6,
                                     logic v1v, logic v2v, logic r1v);
    bit amt_ok;
    amt_ok = (f3 == OPIVV) ? v1v : r1v;
    return uv && (f3 inside {OPIVV, OPIVX, OPIVI}) &&
           (f6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA}) && v2v && amt_ok;
  endfunction

  // expected result, element by element in integer arithmetic
  function automatic vlen_t ref_result(funct3_e f3, funct6_e f6, vxrm_e rm, eew_e ew,
                                       vlen_t v1, vlen_t v2, xlen_t r1);
    vlen_t           res;
    longint unsigned mask;
    longint unsigned e;
    longint unsigned sh;
    longint unsigned low;
    longint          se;
    int              w;
    int              a;
    bit              r;
    bit              s;
    bit              l;
    bit              inc;
    res  = '0;
    w    = elem_width(ew);
    mask = (64'd1 << w) - 1;
    for (int i = 0; i < VLEN / w; i++) begin
      e = 64'(v2 >> (i * w)) & mask;
      if (f3 == OPIVV) begin
        a = int'((64'(v1 >> (i * w)) & mask) % w);
      end else begin
        a = int'(r1 % w);
      end
      se = e[w-1] ? longint'(e) - longint'(64'd1 << w) : longint'(e);
      case (f6)
        VSLL: begin
          sh = (e << a) & mask;
        end
        VSRL, VSSRL: begin
          sh = e >> a;
        end
        default: begin
          se = se >>> a;
          sh = se & mask;
        end
      endcase
      inc = 1'b0;
      if ((f6 == VSSRL || f6 == VSSRA) && a > 0) begin
        low = e & ((64'd1 << a) - 1);
        r   = low[a-1];
        s   = (low & ((64'd1 << (a - 1)) - 1)) != 0;
        l   = sh[0];
        case (rm)
          RNU:     inc = r;
          RNE:     inc = r && (s || l);
          RDN:     inc = 1'b0;
          default: inc = !l && (r || s);
        endcase
      end
      res = res | (vlen_t'((sh + inc) & mask) << (i * w));
    end
    return res;
  endfunction

  function automatic vlen_t rand_vec();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // same value in every element slot
  function automatic vlen_t splat(eew_e ew, longint unsigned val);
    vlen_t v;
    int    w;
    v = '0;
    w = elem_width(ew);
    for (int i = 0; i < VLEN / w; i++) begin
      v = v | (vlen_t'(val) << (i * w));
    end
    return v;
  endfunction

  // even lanes hold an exact tie, odd lanes only sticky bits
  function automatic void round_case(eew_e ew, output vlen_t src, output vlen_t amt);
    longint unsigned e;
    int              w;
    int              a;
    src = '0;
    amt = '0;
    w   = elem_width(ew);
    for (int i = 0; i < VLEN / w; i++) begin
      a   = 1 + i % (w - 1);
      e   = 64'($urandom) << a;
      e   = e | ((i % 2 == 0) ? (64'd1 << (a - 1)) : 64'd1);
      src = src | (vlen_t'(e & ((64'd1 << w) - 1)) << (i * w));
      amt = amt | (vlen_t'(a) << (i * w));
    end
  endfunction

  task automatic send(funct3_e f3, funct6_e f6, vxrm_e rm, eew_e ew, vlen_t v1, vlen_t v2,
                      xlen_t r1, logic uv = 1'b1, logic v1v = 1'b1, logic v2v = 1'b1,
                      logic r1v = 1'b1);
    uop_valid      = uv;
    funct3         = f3;
    funct6         = f6;
    vxrm           = rm;
    vs2_eew        = ew;
    vs1_data       = v1;
    vs1_data_valid = v1v;
    vs2_data       = v2;
    vs2_data_valid = v2v;
    rs1_data       = r1;
    rs1_data_valid = r1v;
    // issue cycle is the one the uop is driven in
    if (is_accepted(uv, f3, f6, v1v, v2v, r1v)) begin
      exp_q.push_back(ref_result(f3, f6, rm, ew, v1, v2, r1));
      issue_q.push_back(cycle_cnt);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(string name);
    uop_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (LAT + 1) @(posedge clk);
    #1;
    tests_run++;
    if (err_count == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  // results are sampled half a cycle after the edge that loads them
  always @(negedge clk) begin : compare
    vlen_t exp_data;
    int    issued;
    if (!arst_n) begin
      assert (result_valid === 1'b0) else begin
        $display("error at %0t: result_valid high during reset", $time);
        err_count++;
      end
    end else begin
      assert (!$isunknown(result_valid)) else begin
        $display("error at %0t: result_valid is unknown", $time);
        err_count++;
      end
      if (exp_q.size() != 0 && cycle_cnt > issue_q[0] + LAT) begin
        $display("at %0t the result of the uop issued in cycle %0d never arrived",
                 $time, issue_q[0]);
        err_count++;
        void'(exp_q.pop_front());
        void'(issue_q.pop_front());
      end
      if (result_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("at %0t result_valid rose with no accepted uop pending", $time);
          err_count++;
        end else begin
          exp_data = exp_q.pop_front();
          issued   = issue_q.pop_front();
          assert (cycle_cnt - issued == LAT) else begin
            $display("error at %0t: latency %0d cycles", $time, cycle_cnt - issued);
            err_count++;
          end
          assert (result_data === exp_data) else begin
            $display("error at %0t: result %h, expected %h", $time, result_data, exp_data);
            err_count++;
          end
        end
      end
    end
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    vlen_t src;
    vlen_t amt;
    int    w;
    void'($urandom(32'hfa45));
    arst_n         = 1'b0;
    uop_valid      = 1'b0;
    funct3         = OPIVV;
    funct6         = VSLL;
    vxrm           = RNU;
    vs2_eew        = EEW8;
    vs1_data       = '0;
    vs1_data_valid = 1'b0;
    vs2_data       = '0;
    vs2_data_valid = 1'b0;
    rs1_data       = '0;
    rs1_data_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    finish_test("reset");

    // max amount with negative elements, then random amounts
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < 3; j++) begin
        w = elem_width(widths[j]);
        send(OPIVV, plain_ops[k], RNU, widths[j], rand_vec() | splat(widths[j], w - 1),
             rand_vec() | splat(widths[j], 64'd1 << (w - 1)), '0);
        send(OPIVV, plain_ops[k], RNU, widths[j], rand_vec(), rand_vec(), '0);
      end
    end
    finish_test("plain vector amounts");

    for (int c = 1; c < 3; c++) begin
      for (int k = 0; k < 3; k++) begin
        for (int j = 0; j < 3; j++) begin
          send(cats[c], plain_ops[k], RNU, widths[j], rand_vec(), rand_vec(), $urandom);
        end
      end
    end
    finish_test("scalar and immediate amounts");

    for (int k = 0; k < 2; k++) begin
      for (int m = 0; m < 4; m++) begin
        for (int j = 0; j < 3; j++) begin
          round_case(widths[j], src, amt);
          send(OPIVV, scale_ops[k], modes[m], widths[j], amt, src, '0);
          // all ones shifted by one wraps to zero under vssra
          send(OPIVV, scale_ops[k], modes[m], widths[j], splat(widths[j], 1), '1, '0);
          send(OPIVX, scale_ops[k], modes[m], widths[j], rand_vec(), rand_vec(), $urandom);
        end
      end
    end
    finish_test("scaling shifts");

    send(OPIVV, VSRL, RNU, EEW8, rand_vec(), rand_vec(), '0, 1'b0, 1'b1, 1'b1, 1'b1);
    send(OPIVV, VSRL, RNU, EEW16, rand_vec(), rand_vec(), '0, 1'b1, 1'b0, 1'b1, 1'b1);
    send(OPIVX, VSRA, RNU, EEW32, rand_vec(), rand_vec(), $urandom, 1'b1, 1'b1, 1'b0, 1'b1);
    send(OPIVI, VSLL, RNU, EEW8, rand_vec(), rand_vec(), $urandom, 1'b1, 1'b1, 1'b1, 1'b0);
    send(OPIVV, VSLL, RNU, EEW16, rand_vec(), rand_vec(), '0);
    send(funct3_e'(3'b001), VSLL, RNU, EEW8, rand_vec(), rand_vec(), '0);
    send(OPIVV, VNSRL, RNU, EEW16, rand_vec(), rand_vec(), '0);
    send(OPIVV, VNSRA, RNE, EEW16, rand_vec(), rand_vec(), '0);
    send(OPIVX, VNCLIPU, RDN, EEW8, rand_vec(), rand_vec(), $urandom);
    send(OPIVI, VNCLIP, ROD, EEW8, rand_vec(), rand_vec(), $urandom);
    finish_test("rejected uops");

    for (int n = 0; n < N_RANDOM; n++) begin
      send(cats[$urandom_range(2)], kept_ops[$urandom_range(4)], modes[$urandom_range(3)],
           widths[$urandom_range(2)], rand_vec(), rand_vec(), $urandom);
    end
    finish_test("random back-to-back stream");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
vshift_pkg.sv
vshift_ctrl.sv
vshift_amount_gen.sv
vshift_lane_array.sv
vshift_result_mux.sv
vshift_unit.sv
vshift_properties.sv
tb_vshift_unit.sv

/* Bender.yml */
package:
  name: vshift_unit

sources:
  - include_dirs:
      - .
    files:
      - vshift_pkg.sv
      - vshift_ctrl.sv
      - vshift_amount_gen.sv
      - vshift_lane_array.sv
      - vshift_result_mux.sv
      - vshift_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - vshift_properties.sv
      - tb_vshift_unit.sv
